// ==== rtl/mem_pkg.sv ====
package mem_pkg;

	// cpu word and ddr line widths
	localparam int WORD_W = 32;
	localparam int LINE_W = 128;
	localparam int WORDS_PER_LINE = LINE_W / WORD_W;

	// model footprint in ddr lines
	localparam int MODEL_LINES = 16;
	localparam int LINE_ADDR_W = 4;

	// word index inside a line
	localparam int LANE_W = 2;

	// byte offset bits below a word and below a line
	localparam int BYTE_OFS_W = 2;
	localparam int LINE_OFS_W = 4;

	typedef logic [WORD_W-1:0] word_t;
	typedef logic [LINE_W-1:0] line_t;
	typedef logic [LINE_ADDR_W-1:0] line_addr_t;
	typedef logic [LANE_W-1:0] lane_t;

	// one application write, a full line at a line index
	typedef struct packed {
		line_addr_t addr;
		line_t      data;
	} app_wr_t;

endpackage

// ==== rtl/axi_pkg.sv ====
package axi_pkg;

	// axi read channel field widths
	localparam int ADDR_W = 32;
	localparam int ID_W = 4;
	localparam int LEN_W = 8;
	localparam int DATA32_W = 32;
	localparam int DATA128_W = 128;

	// lines per burst from the read tester
	localparam int BURST_LINES = 2;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [ID_W-1:0] id_t;
	typedef logic [LEN_W-1:0] len_t;

	// id carried by every tester burst
	localparam id_t RD_ID = 4'h1;

	// read address, 44 bits
	typedef struct packed {
		id_t   id;
		addr_t addr;
		len_t  len;
	} ar_t;

	// read data on the cpu side
	typedef struct packed {
		id_t                 id;
		logic [DATA32_W-1:0] data;
		logic                last;
	} r32_t;

	// read data on the ddr side
	typedef struct packed {
		id_t                  id;
		logic [DATA128_W-1:0] data;
		logic                 last;
	} r128_t;

endpackage

// ==== rtl/model_loader.sv ====
`timescale 1ns/10ps

module model_loader (
	input  logic             clk_osc,
	input  logic             rst_n,
	// incoming model words
	input  logic             load_valid,
	input  mem_pkg::word_t   load_data,
	output logic             load_ready,
	// line writes toward the ddr store
	output logic             app_cmd_en,
	output mem_pkg::app_wr_t app_wr,
	input  logic             app_rdy,
	output logic             init_model_complete
);

	typedef enum logic [1:0] {
		S_COLLECT,
		S_WRITE,
		S_DONE
	} state_t;

	state_t state;
	mem_pkg::lane_t word_cnt;
	mem_pkg::line_addr_t line_cnt;
	mem_pkg::line_t line_buf;

	// words only taken while collecting
	assign load_ready = (state == S_COLLECT);
	assign app_cmd_en = (state == S_WRITE);
	assign init_model_complete = (state == S_DONE);

	// write payload held by the fsm while waiting on app_rdy
	assign app_wr.addr = line_cnt;
	assign app_wr.data = line_buf;

	always_ff @(posedge clk_osc or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_COLLECT;
			word_cnt <= '0;
			line_cnt <= '0;
		end else begin
			case (state)
				S_COLLECT: begin
					if (load_valid) begin
						word_cnt <= word_cnt + 1'b1;
						// fourth word closes the line
						if (word_cnt == mem_pkg::lane_t'(mem_pkg::WORDS_PER_LINE - 1)) begin
							state <= S_WRITE;
						end
					end
				end
				S_WRITE: begin
					if (app_rdy) begin
						line_cnt <= line_cnt + 1'b1;
						if (line_cnt == mem_pkg::line_addr_t'(mem_pkg::MODEL_LINES - 1)) begin
							state <= S_DONE;
						end else begin
							state <= S_COLLECT;
						end
					end
				end
				default: begin
					// model loaded, stay here until reset
					state <= S_DONE;
				end
			endcase
		end
	end

	// shift in from the top, first word lands in lane 0
	always_ff @(posedge clk_osc) begin
		if (load_valid && load_ready) begin
			line_buf <= {load_data, line_buf[mem_pkg::LINE_W-1:mem_pkg::WORD_W]};
		end
	end

	// completion is sticky and no write follows it
	a_done_final: assert property (@(posedge clk_osc) disable iff (!rst_n)
		init_model_complete |=> init_model_complete && !app_cmd_en)
		else $error("write command after model load");

endmodule

// ==== rtl/ddr_memory.sv ====
`timescale 1ns/10ps

module ddr_memory (
	input  logic             clk_osc,
	input  logic             rst_n,
	// application write port
	input  logic             app_cmd_en,
	input  mem_pkg::app_wr_t app_wr,
	output logic             app_rdy,
	// axi read address
	input  logic             ar_valid,
	input  axi_pkg::ar_t     ar,
	output logic             ar_ready,
	// axi read data
	output logic             r_valid,
	output axi_pkg::r128_t   r,
	input  logic             r_ready
);

	// behavioural line store in place of the dram
	mem_pkg::line_t mem [mem_pkg::MODEL_LINES];

	logic busy;
	axi_pkg::len_t beat_left;
	mem_pkg::line_addr_t line_ptr;
	axi_pkg::id_t burst_id;

	// app writes lose to an active read burst
	assign app_rdy = !busy;
	// single burst in flight
	assign ar_ready = !busy;

	always_ff @(posedge clk_osc) begin
		if (app_cmd_en && app_rdy) begin
			mem[app_wr.addr] <= app_wr.data;
		end
	end

	// burst control
	always_ff @(posedge clk_osc or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			beat_left <= '0;
		end else if (!busy) begin
			if (ar_valid) begin
				busy <= 1'b1;
				beat_left <= ar.len;
			end
		end else if (r_ready) begin
			if (beat_left == '0) begin
				busy <= 1'b0;
			end else begin
				beat_left <= beat_left - 1'b1;
			end
		end
	end

	// line pointer from address bits 7..4, steps on each beat
	always_ff @(posedge clk_osc) begin
		if (!busy && ar_valid) begin
			line_ptr <= ar.addr[mem_pkg::LINE_OFS_W +: mem_pkg::LINE_ADDR_W];
			burst_id <= ar.id;
		end else if (busy && r_ready && beat_left != '0) begin
			line_ptr <= line_ptr + 1'b1;
		end
	end

	// first beat the cycle after ar
	assign r_valid = busy;
	assign r.id = burst_id;
	assign r.data = mem[line_ptr];
	assign r.last = (beat_left == '0);

	// beat held under back-pressure
	a_r_stable: assert property (@(posedge clk_osc) disable iff (!rst_n)
		r_valid && !r_ready |=> r_valid && $stable(r))
		else $error("r beat changed while stalled");

endmodule

// ==== rtl/axi_width_adapter.sv ====
`timescale 1ns/10ps

module axi_width_adapter (
	input  logic           clk_osc,
	input  logic           rst_n,
	// 32-bit slave side
	input  logic           s_ar_valid,
	input  axi_pkg::ar_t   s_ar,
	output logic           s_ar_ready,
	output logic           s_r_valid,
	output axi_pkg::r32_t  s_r,
	input  logic           s_r_ready,
	// 128-bit master side
	output logic           m_ar_valid,
	output axi_pkg::ar_t   m_ar,
	input  logic           m_ar_ready,
	input  logic           m_r_valid,
	input  axi_pkg::r128_t m_r,
	output logic           m_r_ready
);

	// ar register toward the ddr side
	axi_pkg::ar_t ar_q;
	logic ar_pend;

	// start word per accepted burst, two deep
	mem_pkg::lane_t ofs_q [2];
	logic ofs_wr;
	logic ofs_rd;
	logic [1:0] ofs_cnt;

	// line buffer drained one lane per beat
	mem_pkg::word_t [mem_pkg::WORDS_PER_LINE-1:0] buf_words;
	logic buf_valid;
	logic buf_last;
	axi_pkg::id_t buf_id;
	mem_pkg::lane_t lane;
	logic first_line;

	logic ar_push;
	logic line_load;
	logic ofs_pop;
	logic lane_end;

	assign s_ar_ready = (!ar_pend || m_ar_ready) && (ofs_cnt != 2'd2);
	assign ar_push = s_ar_valid && s_ar_ready;

	assign m_ar_valid = ar_pend;
	assign m_ar = ar_q;

	always_ff @(posedge clk_osc or negedge rst_n) begin
		if (!rst_n) begin
			ar_pend <= 1'b0;
		end else if (ar_push) begin
			ar_pend <= 1'b1;
		end else if (m_ar_ready) begin
			ar_pend <= 1'b0;
		end
	end

	// (len+1)/4 - 1 line beats
	always_ff @(posedge clk_osc) begin
		if (ar_push) begin
			ar_q.id <= s_ar.id;
			ar_q.addr <= s_ar.addr;
			ar_q.len <= axi_pkg::len_t'((int'(s_ar.len) + 1) / mem_pkg::WORDS_PER_LINE - 1);
			ofs_q[ofs_wr] <= s_ar.addr[mem_pkg::BYTE_OFS_W +: mem_pkg::LANE_W];
		end
	end

	// taking a line when the buffer empties
	assign lane_end = (lane == mem_pkg::lane_t'(mem_pkg::WORDS_PER_LINE - 1));
	assign m_r_ready = !buf_valid || (s_r_ready && lane_end);
	assign line_load = m_r_valid && m_r_ready;
	assign ofs_pop = line_load && first_line;

	always_ff @(posedge clk_osc or negedge rst_n) begin
		if (!rst_n) begin
			ofs_wr <= 1'b0;
			ofs_rd <= 1'b0;
			ofs_cnt <= '0;
		end else begin
			if (ar_push) begin
				ofs_wr <= !ofs_wr;
			end
			if (ofs_pop) begin
				ofs_rd <= !ofs_rd;
			end
			case ({ar_push, ofs_pop})
				2'b10: ofs_cnt <= ofs_cnt + 1'b1;
				2'b01: ofs_cnt <= ofs_cnt - 1'b1;
				default: ofs_cnt <= ofs_cnt;
			endcase
		end
	end

	always_ff @(posedge clk_osc or negedge rst_n) begin
		if (!rst_n) begin
			buf_valid <= 1'b0;
			lane <= '0;
			first_line <= 1'b1;
		end else if (line_load) begin
			buf_valid <= 1'b1;
			// only the first line of a burst starts mid-line
			lane <= first_line ? ofs_q[ofs_rd] : '0;
			first_line <= m_r.last;
		end else if (s_r_valid && s_r_ready) begin
			if (lane_end) begin
				buf_valid <= 1'b0;
			end else begin
				lane <= lane + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_osc) begin
		if (line_load) begin
			buf_words <= m_r.data;
			buf_last <= m_r.last;
			buf_id <= m_r.id;
		end
	end

	assign s_r_valid = buf_valid;
	assign s_r.id = buf_id;
	assign s_r.data = buf_words[lane];
	// last only on the top lane of the final line
	assign s_r.last = buf_last && lane_end;

	a_len_whole_lines: assert property (@(posedge clk_osc) disable iff (!rst_n)
		ar_push |-> ((int'(s_ar.len) + 1) % mem_pkg::WORDS_PER_LINE) == 0)
		else $error("burst length not a whole number of lines");

endmodule

// ==== rtl/ddr_read_test.sv ====
`timescale 1ns/10ps

module ddr_read_test (
	input  logic           clk_osc,
	input  logic           rst_n,
	input  logic           init_model_complete,
	// axi read master
	output logic           ar_valid,
	output axi_pkg::ar_t   ar,
	input  logic           ar_ready,
	input  logic           r_valid,
	input  axi_pkg::r32_t  r,
	output logic           r_ready,
	// read-out stream
	output logic           rd_valid,
	output mem_pkg::word_t rd_data,
	output logic           rd_last,
	input  logic           rd_ready
);

	typedef enum logic [1:0] {
		S_WAIT,
		S_ISSUE,
		S_FINISHED
	} state_t;

	state_t state;
	mem_pkg::line_addr_t burst_cnt;

	// bursts go out back to back, adapter throttles them
	assign ar_valid = (state == S_ISSUE);
	assign ar.id = axi_pkg::RD_ID;
	assign ar.addr = axi_pkg::addr_t'(burst_cnt)
		* axi_pkg::addr_t'(axi_pkg::BURST_LINES << mem_pkg::LINE_OFS_W);
	assign ar.len = axi_pkg::len_t'(axi_pkg::BURST_LINES * mem_pkg::WORDS_PER_LINE - 1);

	always_ff @(posedge clk_osc or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_WAIT;
			burst_cnt <= '0;
		end else begin
			case (state)
				S_WAIT: begin
					// hold off until the model is in ddr
					if (init_model_complete) begin
						state <= S_ISSUE;
					end
				end
				S_ISSUE: begin
					if (ar_ready) begin
						burst_cnt <= burst_cnt + 1'b1;
						if (burst_cnt == mem_pkg::line_addr_t'(
							mem_pkg::MODEL_LINES / axi_pkg::BURST_LINES - 1)) begin
							state <= S_FINISHED;
						end
					end
				end
				default: begin
					state <= S_FINISHED;
				end
			endcase
		end
	end

	// read data straight out, outside ready stalls the chain
	assign rd_valid = r_valid;
	assign rd_data = r.data;
	assign rd_last = r.last;
	assign r_ready = rd_ready;

	// id survives adapter and store round trip
	a_rid: assert property (@(posedge clk_osc) disable iff (!rst_n)
		r_valid |-> r.id == axi_pkg::RD_ID)
		else $error("read data with foreign id");

endmodule

// ==== rtl/soc_top.sv ====
`timescale 1ns/10ps

module soc_top (
	input  logic           clk_osc,
	input  logic           rst_n,
	// model load stream
	input  logic           load_valid,
	input  mem_pkg::word_t load_data,
	output logic           load_ready,
	// read-out stream
	output logic           rd_valid,
	output mem_pkg::word_t rd_data,
	output logic           rd_last,
	input  logic           rd_ready,
	// was the board led
	output logic           init_model_complete
);

	// loader to store
	logic app_cmd_en;
	mem_pkg::app_wr_t app_wr;
	logic app_rdy;

	// tester to adapter, 32-bit
	logic ar32_valid;
	axi_pkg::ar_t ar32;
	logic ar32_ready;
	logic r32_valid;
	axi_pkg::r32_t r32;
	logic r32_ready;

	// adapter to store, 128-bit
	logic ar128_valid;
	axi_pkg::ar_t ar128;
	logic ar128_ready;
	logic r128_valid;
	axi_pkg::r128_t r128;
	logic r128_ready;

	model_loader u_loader (
		.clk_osc(clk_osc), .rst_n(rst_n),
		.load_valid(load_valid), .load_data(load_data), .load_ready(load_ready),
		.app_cmd_en(app_cmd_en), .app_wr(app_wr), .app_rdy(app_rdy),
		.init_model_complete(init_model_complete)
	);

	ddr_memory u_ddr (
		.clk_osc(clk_osc), .rst_n(rst_n),
		.app_cmd_en(app_cmd_en), .app_wr(app_wr), .app_rdy(app_rdy),
		.ar_valid(ar128_valid), .ar(ar128), .ar_ready(ar128_ready),
		.r_valid(r128_valid), .r(r128), .r_ready(r128_ready)
	);

	axi_width_adapter u_adapter (
		.clk_osc(clk_osc), .rst_n(rst_n),
		.s_ar_valid(ar32_valid), .s_ar(ar32), .s_ar_ready(ar32_ready),
		.s_r_valid(r32_valid), .s_r(r32), .s_r_ready(r32_ready),
		.m_ar_valid(ar128_valid), .m_ar(ar128), .m_ar_ready(ar128_ready),
		.m_r_valid(r128_valid), .m_r(r128), .m_r_ready(r128_ready)
	);

	ddr_read_test u_rd_test (
		.clk_osc(clk_osc), .rst_n(rst_n),
		.init_model_complete(init_model_complete),
		.ar_valid(ar32_valid), .ar(ar32), .ar_ready(ar32_ready),
		.r_valid(r32_valid), .r(r32), .r_ready(r32_ready),
		.rd_valid(rd_valid), .rd_data(rd_data), .rd_last(rd_last), .rd_ready(rd_ready)
	);

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// reset low for four cycles, released just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

// ==== test/tb_soc.sv ====
`timescale 1ns/10ps

module tb_soc;

	localparam int N_WORDS = mem_pkg::MODEL_LINES * mem_pkg::WORDS_PER_LINE;
	localparam int BURST_WORDS = axi_pkg::BURST_LINES * mem_pkg::WORDS_PER_LINE;
	localparam int WAIT_LIMIT = 200;
	localparam int READ_LIMIT = 2000;

	logic clk_osc;
	logic rst_n;
	logic load_valid;
	mem_pkg::word_t load_data;
	logic load_ready;
	logic rd_valid;
	mem_pkg::word_t rd_data;
	logic rd_last;
	logic rd_ready;
	logic init_model_complete;

	// model image as offered on the load stream
	mem_pkg::word_t load_words [N_WORDS];

	int loads_seen = 0;
	int reads_seen = 0;
	int data_errors = 0;
	int proto_errors = 0;

	// last read-out beat that was held off
	logic stall_q = 1'b0;
	mem_pkg::word_t stall_data;
	logic stall_last;

	tb_clock u_clock (
		.clk(clk_osc),
		.rst_n(rst_n)
	);

	soc_top DUT (
		.clk_osc(clk_osc), .rst_n(rst_n),
		.load_valid(load_valid), .load_data(load_data), .load_ready(load_ready),
		.rd_valid(rd_valid), .rd_data(rd_data), .rd_last(rd_last), .rd_ready(rd_ready),
		.init_model_complete(init_model_complete)
	);

	// word idx is lane idx%4 of line idx/4 and lines come back in address order
	function automatic mem_pkg::word_t expected_word(input int idx);
		int line_idx;
		int lane_idx;
		line_idx = idx / mem_pkg::WORDS_PER_LINE;
		lane_idx = idx % mem_pkg::WORDS_PER_LINE;
		return load_words[line_idx * mem_pkg::WORDS_PER_LINE + lane_idx];
	endfunction

	// one tester burst is two lines of four words
	function automatic logic expected_last(input int idx);
		return (idx % BURST_WORDS) == BURST_WORDS - 1;
	endfunction

	task automatic give_up(input string what);
		$display("timeout while waiting for %s", what);
		$display("sim failed");
		$finish;
	endtask

	// starts just after a rising edge and returns just after the edge that takes the word
	task automatic send_word(input mem_pkg::word_t w);
		int n;
		load_valid = 1'b1;
		load_data = w;
		n = 0;
		// ready seen at the falling edge means the next edge takes the word
		@(negedge clk_osc);
		while (!load_ready && n < WAIT_LIMIT) begin
			n++;
			@(negedge clk_osc);
		end
		if (!load_ready) give_up("load_ready");
		@(posedge clk_osc);
		#2;
		load_valid = 1'b0;
	endtask

	// random back-pressure on the read-out stream
	initial begin
		forever begin
			@(posedge clk_osc);
			#2;
			rd_ready = ($urandom_range(0, 3) != 0);
		end
	end

	initial begin
		int n;
		void'($urandom(32'h3d56118c));
		load_valid = 1'b0;
		load_data = '0;
		rd_ready = 1'b0;
		for (int i = 0; i < N_WORDS; i++) begin
			load_words[i] = $urandom();
		end

		n = 0;
		while (rst_n !== 1'b1 && n < WAIT_LIMIT) begin
			@(posedge clk_osc);
			n++;
		end
		if (rst_n !== 1'b1) give_up("reset release");
		@(posedge clk_osc);
		#2;

		// model load with random gaps
		for (int i = 0; i < N_WORDS; i++) begin
			repeat ($urandom_range(0, 3)) begin
				@(posedge clk_osc);
				#2;
			end
			send_word(load_words[i]);
		end

		// flag follows the last line write by one cycle
		n = 0;
		while (!init_model_complete && n < 3) begin
			@(negedge clk_osc);
			n++;
		end
		assert (init_model_complete)
		else begin
			proto_errors++;
			$display("[ERROR] %0t init_model_complete expected 1 got %b", $time,
				init_model_complete);
		end
		@(posedge clk_osc);
		#2;

		// words offered after completion must be refused
		load_valid = 1'b1;
		for (int i = 0; i < 16; i++) begin
			load_data = $urandom();
			@(posedge clk_osc);
			#2;
		end
		load_valid = 1'b0;

		n = 0;
		while (reads_seen < N_WORDS && n < READ_LIMIT) begin
			@(posedge clk_osc);
			n++;
		end
		if (reads_seen < N_WORDS) give_up("read-out words");
		// a stray extra word would turn up here
		repeat (20) @(posedge clk_osc);

		assert (reads_seen == N_WORDS)
		else begin
			proto_errors++;
			$display("[ERROR] %0t read-out count expected %0d got %0d", $time, N_WORDS,
				reads_seen);
		end

		$display("loaded %0d, read %0d, data errors %0d, protocol errors %0d",
			loads_seen, reads_seen, data_errors, proto_errors);
		if (data_errors == 0 && proto_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

	// sampled mid-cycle where inputs and outputs are settled
	always @(negedge clk_osc) begin
		mem_pkg::word_t exp_word;
		logic exp_last;
		if (rst_n) begin
			// flag only after all 64 words went in
			assert (!init_model_complete || loads_seen == N_WORDS)
			else begin
				proto_errors++;
				$display("[ERROR] %0t init_model_complete expected 0 got 1 after %0d loads",
					$time, loads_seen);
			end
			assert (!(init_model_complete && load_ready))
			else begin
				proto_errors++;
				$display("[ERROR] %0t load_ready expected 0 got 1", $time);
			end
			if (load_valid && load_ready) begin
				loads_seen++;
			end
			assert (loads_seen <= N_WORDS)
			else begin
				proto_errors++;
				$display("load word accepted beyond the model size at %0t", $time);
			end

			// held beat must not move
			if (stall_q) begin
				assert (rd_valid)
				else begin
					proto_errors++;
					$display("[ERROR] %0t rd_valid expected 1 got 0", $time);
				end
				assert (rd_data == stall_data)
				else begin
					proto_errors++;
					$display("[ERROR] %0t rd_data expected %h got %h", $time, stall_data,
						rd_data);
				end
				assert (rd_last == stall_last)
				else begin
					proto_errors++;
					$display("[ERROR] %0t rd_last expected %b got %b", $time, stall_last,
						rd_last);
				end
			end

			if (rd_valid && rd_ready) begin
				assert (reads_seen < N_WORDS)
				else begin
					proto_errors++;
					$display("read-out word beyond the model size at %0t", $time);
				end
				if (reads_seen < N_WORDS) begin
					exp_word = expected_word(reads_seen);
					exp_last = expected_last(reads_seen);
					assert (rd_data == exp_word)
					else begin
						data_errors++;
						$display("[ERROR] %0t rd_data expected %h got %h", $time, exp_word,
							rd_data);
					end
					assert (rd_last == exp_last)
					else begin
						proto_errors++;
						$display("[ERROR] %0t rd_last expected %b got %b", $time, exp_last,
							rd_last);
					end
				end
				reads_seen++;
			end

			stall_q = rd_valid && !rd_ready;
			stall_data = rd_data;
			stall_last = rd_last;
		end
	end

endmodule

// ==== compile.f ====
rtl/mem_pkg.sv
rtl/axi_pkg.sv
rtl/model_loader.sv
rtl/ddr_memory.sv
rtl/axi_width_adapter.sv
rtl/ddr_read_test.sv
rtl/soc_top.sv
test/tb_clock.sv
test/tb_soc.sv

// ==== run.sh ====
#!/bin/sh
# build and run tb_soc with verilator, pass only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f compile.f --top-module tb_soc -Mdir obj_dir -o sim_soc
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

out=$(./obj_dir/sim_soc)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "sim passed"; then
	exit 0
else
	exit 1
fi
